// File: design/cachePkg.sv
package cachePkg;

  // Geometry
  localparam int addrBits     = 32;
  localparam int wordBits     = 32;
  localparam int numSets      = 16;
  localparam int wordsPerLine = 4;
  localparam int indexBits    = 4;
  localparam int offsetBits   = 2;
  // Address bits above index, word offset and byte offset
  localparam int tagBits      = addrBits - indexBits - offsetBits - 2;

  // Controller states
  typedef enum logic [2:0] {
    ready,
    writeBack,
    memRead,
    lastRead,
    nextReq,
    flush
  } cacheState;

  typedef enum logic {
    busRead,
    busWrite
  } busOp;

  // CPU request, held stable until done
  typedef struct packed {
    logic                write;
    logic                clean;
    logic [3:0]          byteMask;
    logic [addrBits-1:0] addr;
    logic [wordBits-1:0] wdata;
  } cpuReq;

  typedef struct packed {
    logic                done;
    logic [wordBits-1:0] rdata;
  } cpuResp;

  // One word transfer toward memory
  typedef struct packed {
    busOp                op;
    logic [addrBits-1:0] addr;
    logic [wordBits-1:0] wdata;
  } busXfer;

endpackage

// File: design/cacheController.sv
`timescale 1ns/1ps

module cacheController (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 reqValid,
  input  cachePkg::cpuReq                      req,
  input  logic [cachePkg::tagBits-1:0]         wayTag0,
  input  logic [cachePkg::tagBits-1:0]         wayTag1,
  input  logic [1:0]                           wayValid,
  input  logic [1:0]                           wayDirty,
  input  logic                                 lruWay,
  input  logic [cachePkg::wordBits-1:0]        wayWord0,
  input  logic [cachePkg::wordBits-1:0]        wayWord1,
  input  logic                                 xferDone,
  input  logic [cachePkg::wordBits-1:0]        xferRdata,
  output cachePkg::cpuResp                     resp,
  output logic                                 stall,
  output logic                                 xferValid,
  output cachePkg::busXfer                     xfer,
  output logic [cachePkg::indexBits-1:0]       index,
  output logic [cachePkg::offsetBits-1:0]      wordSel,
  output logic [1:0]                           wayWe,
  output logic [3:0]                           byteMask,
  output logic [cachePkg::wordBits-1:0]        wrData,
  output logic [1:0]                           tagWe,
  output logic [cachePkg::tagBits-1:0]         newTag,
  output logic [1:0]                           setValid,
  output logic [1:0]                           setDirty,
  output logic [1:0]                           clearDirty,
  output logic                                 lruWe,
  output logic                                 lruWrWay
);

  cachePkg::cacheState state;

  logic [1:0]                          wordCnt;
  // Set in the upper bits, way in bit 0
  logic [cachePkg::indexBits:0]        flushCnt;
  logic                                victimWay;

  logic [cachePkg::tagBits-1:0]        reqTag;
  logic [cachePkg::indexBits-1:0]      reqIndex;
  logic [cachePkg::offsetBits-1:0]     reqWord;
  logic [cachePkg::indexBits-1:0]      flushSet;
  logic [1:0]                          wayHit;
  logic                                hit;
  logic                                hitWay;
  logic                                missWay;
  logic                                missDirty;
  logic                                flushDirty;
  logic                                lastWord;
  logic [cachePkg::tagBits-1:0]        victimTag;
  logic [cachePkg::wordBits-1:0]       victimWord;

  // Address split
  assign reqTag   = req.addr[cachePkg::addrBits-1 -: cachePkg::tagBits];
  assign reqIndex = req.addr[cachePkg::offsetBits+2 +: cachePkg::indexBits];
  assign reqWord  = req.addr[2 +: cachePkg::offsetBits];
  assign flushSet = flushCnt[cachePkg::indexBits:1];

  assign wayHit[0] = wayValid[0] & (wayTag0 == reqTag);
  assign wayHit[1] = wayValid[1] & (wayTag1 == reqTag);
  assign hit       = |wayHit;
  assign hitWay    = wayHit[1];

  // Fill an empty way first, else replace the LRU way
  assign missWay    = ~wayValid[0] ? 1'b0 : (~wayValid[1] ? 1'b1 : lruWay);
  assign missDirty  = wayValid[missWay] & wayDirty[missWay];
  assign flushDirty = wayValid[flushCnt[0]] & wayDirty[flushCnt[0]];

  assign lastWord   = xferDone & (wordCnt == 2'd3);
  assign victimTag  = victimWay ? wayTag1 : wayTag0;
  assign victimWord = victimWay ? wayWord1 : wayWord0;

  // The sweep addresses sets from its own counter
  assign index = req.clean ? flushSet : reqIndex;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wordCnt <= 2'd0;
    end else if (xferDone) begin
      wordCnt <= wordCnt + 2'd1;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= cachePkg::ready;
      flushCnt  <= '0;
      victimWay <= 1'b0;
    end else begin
      case (state)
        cachePkg::ready: begin
          if (reqValid) begin
            if (req.clean) begin
              flushCnt <= '0;
              state    <= cachePkg::flush;
            end else if (hit) begin
              state <= cachePkg::nextReq;
            end else begin
              victimWay <= missWay;
              state     <= missDirty ? cachePkg::writeBack : cachePkg::memRead;
            end
          end
        end
        cachePkg::writeBack: begin
          if (lastWord) begin
            state <= req.clean ? cachePkg::flush : cachePkg::memRead;
          end
        end
        cachePkg::memRead: begin
          if (lastWord) begin
            state <= cachePkg::lastRead;
          end
        end
        cachePkg::lastRead: state <= cachePkg::nextReq;
        cachePkg::nextReq:  state <= cachePkg::ready;
        cachePkg::flush: begin
          if (flushDirty) begin
            victimWay <= flushCnt[0];
            state     <= cachePkg::writeBack;
          end else if (&flushCnt) begin
            state <= cachePkg::nextReq;
          end else begin
            flushCnt <= flushCnt + 1'b1;
          end
        end
        default: state <= cachePkg::ready;
      endcase
    end
  end

  always_comb begin
    wordSel    = reqWord;
    wayWe      = 2'b00;
    byteMask   = req.byteMask;
    wrData     = req.wdata;
    tagWe      = 2'b00;
    newTag     = reqTag;
    setValid   = 2'b00;
    setDirty   = 2'b00;
    clearDirty = 2'b00;
    lruWe      = 1'b0;
    lruWrWay   = ~hitWay;
    xferValid  = 1'b0;
    xfer.op    = cachePkg::busRead;
    xfer.addr  = {reqTag, reqIndex, wordCnt, 2'b00};
    xfer.wdata = victimWord;
    case (state)
      cachePkg::writeBack: begin
        wordSel   = wordCnt;
        xferValid = 1'b1;
        xfer.op   = cachePkg::busWrite;
        xfer.addr = {victimTag, index, wordCnt, 2'b00};
        // A flushed line stays valid but is now clean
        if (lastWord && req.clean) begin
          clearDirty[victimWay] = 1'b1;
        end
      end
      cachePkg::memRead: begin
        wordSel   = wordCnt;
        xferValid = 1'b1;
        if (xferDone) begin
          wayWe[victimWay] = 1'b1;
          byteMask         = 4'hf;
          wrData           = xferRdata;
        end
      end
      cachePkg::lastRead: begin
        tagWe[victimWay]      = 1'b1;
        setValid[victimWay]   = 1'b1;
        clearDirty[victimWay] = 1'b1;
      end
      cachePkg::nextReq: begin
        // Line is resident here, so the request hits
        if (!req.clean) begin
          lruWe = 1'b1;
          if (req.write) begin
            wayWe    = wayHit;
            setDirty = wayHit;
          end
        end
      end
      default: ;
    endcase
  end

  assign resp.done  = (state == cachePkg::nextReq);
  assign resp.rdata = hitWay ? wayWord1 : wayWord0;
  assign stall      = (state == cachePkg::ready) ? reqValid : (state != cachePkg::nextReq);

endmodule

// File: design/cacheWays.sv
`timescale 1ns/1ps

module cacheWays (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [cachePkg::indexBits-1:0]    index,
  input  logic [cachePkg::offsetBits-1:0]   wordSel,
  input  logic [1:0]                        wayWe,
  input  logic [3:0]                        byteMask,
  input  logic [cachePkg::wordBits-1:0]     wrData,
  input  logic [1:0]                        tagWe,
  input  logic [cachePkg::tagBits-1:0]      newTag,
  input  logic [1:0]                        setValid,
  input  logic [1:0]                        setDirty,
  input  logic [1:0]                        clearDirty,
  input  logic                              lruWe,
  input  logic                              lruWrWay,
  output logic [cachePkg::tagBits-1:0]      wayTag0,
  output logic [cachePkg::tagBits-1:0]      wayTag1,
  output logic [1:0]                        wayValid,
  output logic [1:0]                        wayDirty,
  output logic                              lruWay,
  output logic [cachePkg::wordBits-1:0]     wayWord0,
  output logic [cachePkg::wordBits-1:0]     wayWord1
);

  logic [cachePkg::tagBits-1:0]  tagOut [2];
  logic [cachePkg::wordBits-1:0] wordOut [2];
  // One bit per set, names the way to replace next
  logic [cachePkg::numSets-1:0]  lruBits;

  for (genvar w = 0; w < 2; w++) begin : gWay
    logic [cachePkg::tagBits-1:0]  tags [cachePkg::numSets];
    logic [cachePkg::wordBits-1:0] data [cachePkg::numSets][cachePkg::wordsPerLine];
    logic [cachePkg::numSets-1:0]  validBits;
    logic [cachePkg::numSets-1:0]  dirtyBits;

    always_ff @(posedge clk) begin
      if (tagWe[w]) begin
        tags[index] <= newTag;
      end
    end

    // Byte lanes written only where the mask is set
    always_ff @(posedge clk) begin
      if (wayWe[w]) begin
        for (int b = 0; b < 4; b++) begin
          if (byteMask[b]) begin
            data[index][wordSel][8*b +: 8] <= wrData[8*b +: 8];
          end
        end
      end
    end

    always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
        validBits <= '0;
        dirtyBits <= '0;
      end else begin
        if (setValid[w]) begin
          validBits[index] <= 1'b1;
        end
        if (setDirty[w]) begin
          dirtyBits[index] <= 1'b1;
        end else if (clearDirty[w]) begin
          dirtyBits[index] <= 1'b0;
        end
      end
    end

    assign tagOut[w]   = tags[index];
    assign wordOut[w]  = data[index][wordSel];
    assign wayValid[w] = validBits[index];
    assign wayDirty[w] = dirtyBits[index];
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lruBits <= '0;
    end else if (lruWe) begin
      lruBits[index] <= lruWrWay;
    end
  end

  assign wayTag0  = tagOut[0];
  assign wayTag1  = tagOut[1];
  assign wayWord0 = wordOut[0];
  assign wayWord1 = wordOut[1];
  assign lruWay   = lruBits[index];

endmodule

// File: design/apbBusMaster.sv
`timescale 1ns/1ps

module apbBusMaster (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            xferValid,
  input  cachePkg::busXfer                xfer,
  input  logic [cachePkg::wordBits-1:0]   PRDATA,
  input  logic                            PREADY,
  output logic                            xferDone,
  output logic [cachePkg::wordBits-1:0]   xferRdata,
  output logic                            PSEL,
  output logic                            PENABLE,
  output logic                            PWRITE,
  output logic [cachePkg::addrBits-1:0]   PADDR,
  output logic [cachePkg::wordBits-1:0]   PWDATA
);

  typedef enum logic [1:0] {
    idle,
    setup,
    access
  } apbPhase;

  apbPhase phase;
  // Transfer held from setup until completion
  cachePkg::busXfer xferReg;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      phase <= idle;
    end else begin
      case (phase)
        idle: begin
          if (xferValid) begin
            phase <= setup;
          end
        end
        setup: phase <= access;
        access: begin
          // Wait states stretch the access phase
          if (PREADY) begin
            phase <= idle;
          end
        end
        default: phase <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (phase == idle && xferValid) begin
      xferReg <= xfer;
    end
  end

  assign PSEL      = (phase != idle);
  assign PENABLE   = (phase == access);
  assign PWRITE    = (xferReg.op == cachePkg::busWrite);
  assign PADDR     = xferReg.addr;
  assign PWDATA    = xferReg.wdata;

  // Completion seen by the controller in the same cycle
  assign xferDone  = (phase == access) & PREADY;
  assign xferRdata = PRDATA;

endmodule

// File: design/dataCache.sv
`timescale 1ns/1ps

module dataCache (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            reqValid,
  input  cachePkg::cpuReq                 req,
  output cachePkg::cpuResp                resp,
  output logic                            stall,
  output logic                            PSEL,
  output logic                            PENABLE,
  output logic                            PWRITE,
  output logic [cachePkg::addrBits-1:0]   PADDR,
  output logic [cachePkg::wordBits-1:0]   PWDATA,
  input  logic [cachePkg::wordBits-1:0]   PRDATA,
  input  logic                            PREADY
);

  // Controller to bus master
  logic                            xferValid;
  cachePkg::busXfer                xfer;
  logic                            xferDone;
  logic [cachePkg::wordBits-1:0]   xferRdata;

  // Controller to ways
  logic [cachePkg::indexBits-1:0]  index;
  logic [cachePkg::offsetBits-1:0] wordSel;
  logic [1:0]                      wayWe;
  logic [3:0]                      byteMask;
  logic [cachePkg::wordBits-1:0]   wrData;
  logic [1:0]                      tagWe;
  logic [cachePkg::tagBits-1:0]    newTag;
  logic [1:0]                      setValid;
  logic [1:0]                      setDirty;
  logic [1:0]                      clearDirty;
  logic                            lruWe;
  logic                            lruWrWay;

  // Ways back to controller
  logic [cachePkg::tagBits-1:0]    wayTag0;
  logic [cachePkg::tagBits-1:0]    wayTag1;
  logic [1:0]                      wayValid;
  logic [1:0]                      wayDirty;
  logic                            lruWay;
  logic [cachePkg::wordBits-1:0]   wayWord0;
  logic [cachePkg::wordBits-1:0]   wayWord1;

  cacheController i_controller (
    .clk        (clk),
    .reset      (reset),
    .reqValid   (reqValid),
    .req        (req),
    .wayTag0    (wayTag0),
    .wayTag1    (wayTag1),
    .wayValid   (wayValid),
    .wayDirty   (wayDirty),
    .lruWay     (lruWay),
    .wayWord0   (wayWord0),
    .wayWord1   (wayWord1),
    .xferDone   (xferDone),
    .xferRdata  (xferRdata),
    .resp       (resp),
    .stall      (stall),
    .xferValid  (xferValid),
    .xfer       (xfer),
    .index      (index),
    .wordSel    (wordSel),
    .wayWe      (wayWe),
    .byteMask   (byteMask),
    .wrData     (wrData),
    .tagWe      (tagWe),
    .newTag     (newTag),
    .setValid   (setValid),
    .setDirty   (setDirty),
    .clearDirty (clearDirty),
    .lruWe      (lruWe),
    .lruWrWay   (lruWrWay)
  );

  cacheWays i_ways (
    .clk        (clk),
    .reset      (reset),
    .index      (index),
    .wordSel    (wordSel),
    .wayWe      (wayWe),
    .byteMask   (byteMask),
    .wrData     (wrData),
    .tagWe      (tagWe),
    .newTag     (newTag),
    .setValid   (setValid),
    .setDirty   (setDirty),
    .clearDirty (clearDirty),
    .lruWe      (lruWe),
    .lruWrWay   (lruWrWay),
    .wayTag0    (wayTag0),
    .wayTag1    (wayTag1),
    .wayValid   (wayValid),
    .wayDirty   (wayDirty),
    .lruWay     (lruWay),
    .wayWord0   (wayWord0),
    .wayWord1   (wayWord1)
  );

  apbBusMaster i_busMaster (
    .clk        (clk),
    .reset      (reset),
    .xferValid  (xferValid),
    .xfer       (xfer),
    .PRDATA     (PRDATA),
    .PREADY     (PREADY),
    .xferDone   (xferDone),
    .xferRdata  (xferRdata),
    .PSEL       (PSEL),
    .PENABLE    (PENABLE),
    .PWRITE     (PWRITE),
    .PADDR      (PADDR),
    .PWDATA     (PWDATA)
  );

endmodule

// File: tests/apbMemoryModel.sv
`timescale 1ns/1ps

module apbMemoryModel (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          PSEL,
  input  logic                          PENABLE,
  input  logic                          PWRITE,
  input  logic [cachePkg::addrBits-1:0] PADDR,
  input  logic [cachePkg::wordBits-1:0] PWDATA,
  output logic [cachePkg::wordBits-1:0] PRDATA,
  output logic                          PREADY
);

  // 256 words at byte addresses 0x000 to 0x3fc
  logic [cachePkg::wordBits-1:0] mem [256];
  logic [1:0]                    waitCnt;
  logic [7:0]                    wordIdx;

  assign wordIdx = PADDR[9:2];

  // Every word differs and depends on its full index
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {i[7:0] ^ 8'h5a, ~i[7:0], i[7:0] + 8'h31, i[7:0]};
    end
  end

  // Wait states for each transfer are drawn in its setup phase
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      waitCnt <= 2'd0;
    end else if (PSEL && !PENABLE) begin
      waitCnt <= 2'($urandom_range(3, 0));
    end else if (PENABLE && waitCnt != 2'd0) begin
      waitCnt <= waitCnt - 2'd1;
    end
  end

  assign PREADY = PENABLE && (waitCnt == 2'd0);
  assign PRDATA = mem[wordIdx];

  // Whole-word writes at the completing edge
  always @(posedge clk) begin
    if (PSEL && PENABLE && PREADY && PWRITE) begin
      mem[wordIdx] <= PWDATA;
    end
  end

endmodule

// File: tests/dataCache_props.sv
`timescale 1ns/1ps

module dataCacheProps (
  input logic                          clk,
  input logic                          reset,
  input logic                          PSEL,
  input logic                          PENABLE,
  input logic                          PWRITE,
  input logic                          PREADY,
  input logic [cachePkg::addrBits-1:0] PADDR
);

  enableNeedsSelect: assert property (@(posedge clk) disable iff (reset)
      PENABLE |-> PSEL)
    else $error("PENABLE high while PSEL is low");

  // Setup lasts one cycle, then the access phase
  setupThenAccess: assert property (@(posedge clk) disable iff (reset)
      (PSEL && !PENABLE) |=> (PSEL && PENABLE))
    else $error("setup phase not followed by an access phase");

  stableWhileWaiting: assert property (@(posedge clk) disable iff (reset)
      (PSEL && PENABLE && !PREADY) |=> ($stable(PADDR) && $stable(PWRITE)))
    else $error("PADDR or PWRITE changed during a wait state");

  noStartDuringAccess: assert property (@(posedge clk) disable iff (reset)
      (PENABLE && !PREADY) |=> !(PSEL && !PENABLE))
    else $error("new transfer started before the access phase completed");

endmodule

bind apbBusMaster dataCacheProps i_props (
  .clk     (clk),
  .reset   (reset),
  .PSEL    (PSEL),
  .PENABLE (PENABLE),
  .PWRITE  (PWRITE),
  .PREADY  (PREADY),
  .PADDR   (PADDR)
);

// File: tests/dataCacheTb.sv
`timescale 1ns/1ps

module dataCacheTb;

  localparam int memWords = 256;
  localparam int timeoutCycles = 2000;

  logic                          clk;
  logic                          reset;
  logic                          reqValid;
  cachePkg::cpuReq               req;
  cachePkg::cpuResp              resp;
  logic                          stall;
  logic                          PSEL;
  logic                          PENABLE;
  logic                          PWRITE;
  logic                          PREADY;
  logic [cachePkg::addrBits-1:0] PADDR;
  logic [cachePkg::wordBits-1:0] PWDATA;
  logic [cachePkg::wordBits-1:0] PRDATA;

  // Memory contents as the CPU should see them
  logic [cachePkg::wordBits-1:0] shadow [memWords];
  int                            loadsChecked;
  int                            loadsIssued;

  dataCache i_dut (
    .clk      (clk),
    .reset    (reset),
    .reqValid (reqValid),
    .req      (req),
    .resp     (resp),
    .stall    (stall),
    .PSEL     (PSEL),
    .PENABLE  (PENABLE),
    .PWRITE   (PWRITE),
    .PADDR    (PADDR),
    .PWDATA   (PWDATA),
    .PRDATA   (PRDATA),
    .PREADY   (PREADY)
  );

  apbMemoryModel i_mem (
    .clk     (clk),
    .reset   (reset),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PWRITE  (PWRITE),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .PRDATA  (PRDATA),
    .PREADY  (PREADY)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] initialWord(input int idx);
    return {idx[7:0] ^ 8'h5a, ~idx[7:0], idx[7:0] + 8'h31, idx[7:0]};
  endfunction

  // Applies a store under its mask and returns the word at the address
  function automatic logic [31:0] refAccess(input cachePkg::cpuReq r);
    logic [7:0] idx;
    idx = r.addr[9:2];
    if (r.write) begin
      for (int b = 0; b < 4; b++) begin
        if (r.byteMask[b]) begin
          shadow[idx][8*b +: 8] = r.wdata[8*b +: 8];
        end
      end
    end
    return shadow[idx];
  endfunction

  task automatic abortRun();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  // Done cycle of each request, sampled mid-cycle
  always @(negedge clk) begin
    logic [31:0] expected;
    if (!reset && resp.done && !req.clean) begin
      expected = refAccess(req);
      if (!req.write) begin
        assert (resp.rdata == expected) else begin
          $display("error at %0t: rdata is %h, expected %h", $time, resp.rdata, expected);
          abortRun();
        end
        loadsChecked++;
      end
    end
  end

  // Holds one request until done, returns the edges it took
  task automatic runRequest(input logic write, input logic clean, input logic [3:0] mask,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            output int cycles);
    logic gotDone;
    @(posedge clk);
    #1;
    reqValid     = 1'b1;
    req.write    = write;
    req.clean    = clean;
    req.byteMask = mask;
    req.addr     = addr;
    req.wdata    = wdata;
    cycles       = 0;
    gotDone      = 1'b0;
    if (!write && !clean) begin
      loadsIssued++;
    end
    while (!gotDone && cycles < timeoutCycles) begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
      gotDone = resp.done;
      // An unfinished request holds the CPU
      if (!gotDone) begin
        assert (stall) else begin
          $display("error at %0t: stall is %b, expected 1", $time, stall);
          abortRun();
        end
      end
    end
    assert (gotDone) else begin
      $display("timeout: request to address %h never finished", addr);
      abortRun();
    end
    assert (!stall) else begin
      $display("error at %0t: stall is %b, expected 0", $time, stall);
      abortRun();
    end
  endtask

  // Every model word must match the shadow after a flush
  task automatic checkMemory();
    for (int i = 0; i < memWords; i++) begin
      assert (i_mem.mem[i] == shadow[i]) else begin
        $display("error at %0t: mem[%0d] is %h, expected %h", $time, i, i_mem.mem[i],
                 shadow[i]);
        abortRun();
      end
    end
  endtask

  initial begin
    int          cycles;
    logic [31:0] addr;
    void'($urandom(32'h8a7f));
    reset        = 1'b1;
    reqValid     = 1'b0;
    req          = '0;
    loadsChecked = 0;
    loadsIssued  = 0;
    for (int i = 0; i < memWords; i++) begin
      shadow[i] = initialWord(i);
    end
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    // Cold miss, then the same word hits
    runRequest(1'b0, 1'b0, 4'h0, 32'h0000_0040, 32'h0, cycles);
    runRequest(1'b0, 1'b0, 4'h0, 32'h0000_0040, 32'h0, cycles);
    assert (cycles == 1) else begin
      $display("error at %0t: done latency is %0d, expected 1", $time, cycles);
      abortRun();
    end

    // Masked stores, each read back
    for (int i = 0; i < 8; i++) begin
      addr = 32'h0000_0080 + 32'(i) * 4;
      runRequest(1'b1, 1'b0, 4'($urandom), addr, $urandom, cycles);
      runRequest(1'b0, 1'b0, 4'h0, addr, 32'h0, cycles);
    end

    // Three tags in set 5, two ways
    runRequest(1'b1, 1'b0, 4'hf, 32'h0000_0050, 32'h1111_aaaa, cycles);
    runRequest(1'b1, 1'b0, 4'hf, 32'h0000_0150, 32'h2222_bbbb, cycles);
    runRequest(1'b1, 1'b0, 4'h3, 32'h0000_0250, 32'h3333_cccc, cycles);
    runRequest(1'b0, 1'b0, 4'h0, 32'h0000_0050, 32'h0, cycles);
    runRequest(1'b0, 1'b0, 4'h0, 32'h0000_0150, 32'h0, cycles);
    runRequest(1'b0, 1'b0, 4'h0, 32'h0000_0250, 32'h0, cycles);

    runRequest(1'b0, 1'b1, 4'h0, 32'h0, 32'h0, cycles);
    checkMemory();

    // Random traffic over the whole model window
    for (int i = 0; i < 300; i++) begin
      addr = {22'd0, 8'($urandom), 2'b00};
      runRequest(1'($urandom), 1'b0, 4'($urandom), addr, $urandom, cycles);
    end
    runRequest(1'b0, 1'b1, 4'h0, 32'h0, 32'h0, cycles);
    checkMemory();

    @(posedge clk);
    #1;
    reqValid = 1'b0;
    // One done pulse per load
    if (loadsChecked == loadsIssued) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("error at %0t: loadsChecked is %0d, expected %0d", $time, loadsChecked,
               loadsIssued);
      abortRun();
    end
  end

endmodule

// File: compile.f
design/cachePkg.sv
design/cacheController.sv
design/cacheWays.sv
design/apbBusMaster.sv
design/dataCache.sv
tests/apbMemoryModel.sv
tests/dataCache_props.sv
tests/dataCacheTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := dataCacheTb
FILELIST  := compile.f
OBJDIR    := obj_dir
LOG       := sim.log

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^TEST PASS$$' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
